// ==== Makefile ====
# Verilator build and run for the feature matching core

TOP := tb_oflow_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f vlog.f -o $(TOP)

# pass only when the testbench prints its pass line
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

// ==== test/tb_oflow_core.sv ====
`timescale 1ns/1ns

module tb_oflow_core;

	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	localparam int LATENCY      = 11;  // query strobe to result strobe
	localparam int WAIT_MAX     = 40;  // cycles before a wait gives up
	localparam int QUIET_CYCLES = 16;

	// buffer load kinds
	localparam logic [2:0] K_RANDOM = 3'd0;  // every slot valid with random bytes
	localparam logic [2:0] K_KEEP   = 3'd1;  // no reload and a new query
	localparam logic [2:0] K_EMPTY  = 3'd2;  // every slot invalid
	localparam logic [2:0] K_ONE    = 3'd3;  // only a0 valid
	localparam logic [2:0] K_PLANT  = 3'd4;  // a0 exact and a1 off by delta among far slots

	typedef struct packed {
		logic [2:0]          kind;
		logic [ADDR_LEN-1:0] a0;
		logic [ADDR_LEN-1:0] a1;
		logic [7:0]          delta;      // score of the a1 plant
		logic                extra;      // stray query while busy
	} row_t;

	// ------------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------------
	localparam int NUM_ROWS = 12;
	localparam row_t ROWS [NUM_ROWS] = '{
		'{K_RANDOM, 4'd0, 4'd0, 8'd0, 1'b0},
		'{K_KEEP,   4'd0, 4'd0, 8'd0, 1'b0},   // back to back
		'{K_KEEP,   4'd0, 4'd0, 8'd0, 1'b1},
		'{K_ONE,    4'd5, 4'd0, 8'd0, 1'b0},
		'{K_EMPTY,  4'd0, 4'd0, 8'd0, 1'b0},
		'{K_PLANT,  4'd2, 4'd3, 8'd0, 1'b0},   // tie inside a pair
		'{K_PLANT,  4'd4, 4'd9, 8'd0, 1'b0},   // tie across pairs
		'{K_PLANT,  4'd5, 4'd8, 8'd0, 1'b0},   // odd address leads across pairs
		'{K_PLANT,  4'd6, 4'd7, 8'd3, 1'b0},   // both in one pair with lane 0 best
		'{K_PLANT,  4'd7, 4'd6, 8'd3, 1'b0},   // lane 1 best
		'{K_RANDOM, 4'd0, 4'd0, 8'd0, 1'b1},
		'{K_KEEP,   4'd0, 4'd0, 8'd0, 1'b0}
	};

	logic                clk;
	logic                reset_N;
	logic                wr_en;
	logic [ADDR_LEN-1:0] wr_addr;
	entry_t              wr_entry;
	logic                query_valid;
	feature_t            query_feat;
	logic                result_valid;
	match_t              result;

	entry_t              shadow [MEM_DEPTH];  // what the buffer should hold
	int                  errors;
	int                  checks;

	oflow_core dut_i (
		.clk, .reset_N,
		.wr_en, .wr_addr, .wr_entry,
		.query_valid, .query_feat,
		.result_valid, .result
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;                  // 8 ns

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic int byte_sad(input feature_t a, input feature_t b);
		int s;
		int d;
		s = 0;
		for (int i = 0; i < FEAT_BYTES; i++) begin
			d = int'(a.desc[i]) - int'(b.desc[i]);
			s += (d < 0) ? -d : d;
		end
		return s;
	endfunction

	// scan in address order
	// only a strictly smaller score displaces
	task automatic model_match(input feature_t q, output cand_t best, output cand_t second);
		int s;
		best.score = MAX_SCORE;
		best.id    = '0;
		second     = best;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			s = shadow[a].valid ? byte_sad(shadow[a].feat, q) : int'(MAX_SCORE);
			if (s < int'(best.score)) begin
				second     = best;
				best.score = SCORE_LEN'(s);
				best.id    = shadow[a].id;
			end else if (s < int'(second.score)) begin
				second.score = SCORE_LEN'(s);
				second.id    = shadow[a].id;
			end
		end
	endtask

	function automatic logic [7:0] rand_byte(input logic [7:0] base, input logic [7:0] mask);
		return base | (8'($urandom) & mask);
	endfunction

	function automatic feature_t rand_feat(input logic [7:0] base, input logic [7:0] mask);
		feature_t f;
		for (int i = 0; i < FEAT_BYTES; i++)
			f.desc[i] = rand_byte(base, mask);
		return f;
	endfunction

	// ------------------------------------------------------------------------
	// drivers and checks
	// ------------------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic load_buffer(input row_t r, input feature_t q);
		entry_t e;
		if (r.kind == K_KEEP)
			return;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			e.id    = {8'($urandom), 4'(a)};              // unique per slot
			e.valid = (r.kind != K_EMPTY);
			e.feat  = rand_feat(8'h00, 8'hff);
			if (r.kind == K_ONE)
				e.valid = (a == int'(r.a0));
			if (r.kind == K_PLANT)
				e.feat = rand_feat(8'hc0, 8'h3f);         // far from any plant
			if (r.kind == K_PLANT && a == int'(r.a0))
				e.feat = q;
			if (r.kind == K_PLANT && a == int'(r.a1)) begin
				e.feat         = q;
				e.feat.desc[0] = q.desc[0] + r.delta;
			end
			@(posedge clk);
			wr_en    <= 1'b1;
			wr_addr  <= ADDR_LEN'(a);
			wr_entry <= e;
			shadow[a] = e;
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// one query and its result strobe
	// n counts cycles after the query
	task automatic run_search(input feature_t q, input logic extra, output int lat,
		output bit seen);
		int n;
		@(posedge clk);
		query_valid <= 1'b1;
		query_feat  <= q;
		@(negedge clk);
		n = 0;
		while (!result_valid && n < WAIT_MAX) begin
			@(posedge clk);
			query_valid <= extra && (n == 3 || n == 8);   // stray queries mid scan and while draining
			query_feat  <= ~q;
			@(negedge clk);
			n++;
		end
		seen = result_valid;
		lat  = n;
		if (!seen) begin
			$display("timeout: no result_valid within %0d cycles of the query", WAIT_MAX);
			errors++;
		end
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check("result_valid", 32'(result_valid), 32'(0));
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		feature_t q;
		cand_t    exp_best;
		cand_t    exp_second;
		int       lat;
		bit       seen;
		row_t     r;

		void'($urandom(32'h8f70_3c1d));
		errors = 0;
		checks = 0;
		reset_N     <= 1'b0;
		wr_en       <= 1'b0;
		wr_addr     <= '0;
		wr_entry    <= '0;
		query_valid <= 1'b0;
		query_feat  <= '0;
		for (int a = 0; a < MEM_DEPTH; a++)
			shadow[a] = '0;                     // buffer comes up empty
		repeat (5) @(posedge clk);
		reset_N <= 1'b1;

		// no strobe and empty slots after reset
		expect_quiet(QUIET_CYCLES);
		check("result.best.score", 32'(result.best.score), 32'(MAX_SCORE));
		check("result.second.score", 32'(result.second.score), 32'(MAX_SCORE));

		for (int k = 0; k < NUM_ROWS; k++) begin
			r = ROWS[k];
			q = (r.kind == K_PLANT) ? rand_feat(8'h00, 8'h3f) : rand_feat(8'h00, 8'hff);
			load_buffer(r, q);
			model_match(q, exp_best, exp_second);
			run_search(q, r.extra, lat, seen);
			if (seen) begin
				check("latency", 32'(lat), 32'(LATENCY));
				check("result.best.score", 32'(result.best.score), 32'(exp_best.score));
				check("result.best.id", 32'(result.best.id), 32'(exp_best.id));
				check("result.second.score", 32'(result.second.score),
					32'(exp_second.score));
				check("result.second.id", 32'(result.second.id), 32'(exp_second.id));
			end
			if (r.extra)
				expect_quiet(QUIET_CYCLES);     // stray query left no second result
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/oflow_calc_min.sv ====
`timescale 1ns/1ns

// ---------------------------------------------------------------------------
// two-smallest tracker
// merges two lane candidates per cycle into the held best / second slots
// ---------------------------------------------------------------------------
module oflow_calc_min (
	input  logic                       clk,
	input  logic                       reset_N,

	input  logic                       clear,       // start of a search
	input  logic                       cand_valid,  // both lanes in lockstep
	input  oflow_score_pkg::cand_t     cand_0,      // lane 0, even address
	input  oflow_score_pkg::cand_t     cand_1,      // lane 1, odd address

	output oflow_score_pkg::match_t    match
);

	import oflow_score_pkg::*;

	cand_t  best_reg;                  // smallest so far
	cand_t  second_reg;                // runner up, never below best_reg

	cand_t  pair_lo;                   // smaller of the incoming pair
	cand_t  pair_hi;
	cand_t  best_nxt;
	cand_t  second_nxt;

	// ------------------------------------------------------------------------
	// order the incoming pair
	// ------------------------------------------------------------------------
	// lane 0 holds the lower address so it wins a tie
	always_comb begin
		if (cand_1.score < cand_0.score) begin
			pair_lo = cand_1;
			pair_hi = cand_0;
		end else begin
			pair_lo = cand_0;
			pair_hi = cand_1;
		end
	end

	// ------------------------------------------------------------------------
	// merge two sorted lists, keep the first two
	// ------------------------------------------------------------------------
	// held slots came from earlier pairs
	// only a strictly smaller score moves them
	always_comb begin
		if (pair_lo.score < best_reg.score) begin
			best_nxt = pair_lo;                  // new leader
			if (pair_hi.score < best_reg.score)
				second_nxt = pair_hi;            // both new ones beat the old best
			else
				second_nxt = best_reg;           // old best slides down
		end else begin
			best_nxt = best_reg;                 // leader stays
			if (pair_lo.score < second_reg.score)
				second_nxt = pair_lo;
			else
				second_nxt = second_reg;         // pair_hi can only be worse
		end
	end

	// ------------------------------------------------------------------------
	// slot registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			best_reg   <= EMPTY_CAND;
			second_reg <= EMPTY_CAND;
		end else if (clear) begin
			best_reg   <= EMPTY_CAND;          // drop the last search
			second_reg <= EMPTY_CAND;
		end else if (cand_valid) begin
			best_reg   <= best_nxt;
			second_reg <= second_nxt;
		end
	end

	// straight from the registers
	assign match.best   = best_reg;
	assign match.second = second_reg;

endmodule

// ==== verilog/oflow_core.sv ====
`timescale 1ns/1ns

// ---------------------------------------------------------------------------
// feature matching core
// buffer -> two similarity lanes -> two-smallest tracker
// ---------------------------------------------------------------------------
module oflow_core (
	input  logic                                clk,
	input  logic                                reset_N,

	// buffer load
	input  logic                                wr_en,
	input  logic [oflow_core_pkg::ADDR_LEN-1:0] wr_addr,
	input  oflow_core_pkg::entry_t              wr_entry,

	// search
	input  logic                                query_valid,
	input  oflow_core_pkg::feature_t            query_feat,
	output logic                                result_valid,
	output oflow_score_pkg::match_t             result
);

	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	logic                rd_en;
	logic [PAIR_LEN-1:0] rd_pair;
	entry_t              entry_0;      // address 2k
	entry_t              entry_1;      // address 2k+1
	logic                rd_valid;
	feature_t            query;
	cand_t               cand_0;
	cand_t               cand_1;
	logic [1:0]          lane_valid;   // one bit per lane
	logic                clear;

	oflow_match_ctrl ctrl_i (
		.clk, .reset_N,
		.query_valid, .query_feat, .query,
		.rd_en, .rd_pair,
		.clear, .result_valid
	);

	oflow_feature_mem mem_i (
		.clk, .reset_N,
		.wr_en, .wr_addr, .wr_entry,
		.rd_en, .rd_pair,
		.entry_0, .entry_1, .rd_valid
	);

	// lane 0 scores the even entry
	oflow_similarity_metric lane_0_i (
		.clk, .reset_N,
		.in_valid(rd_valid), .entry(entry_0), .query,
		.cand(cand_0), .cand_valid(lane_valid[0])
	);

	// lane 1 the odd one
	oflow_similarity_metric lane_1_i (
		.clk, .reset_N,
		.in_valid(rd_valid), .entry(entry_1), .query,
		.cand(cand_1), .cand_valid(lane_valid[1])
	);

	// lanes run in lockstep
	oflow_calc_min min_i (
		.clk, .reset_N,
		.clear, .cand_valid(&lane_valid),
		.cand_0, .cand_1,
		.match(result)
	);

endmodule

// ==== verilog/oflow_core_pkg.sv ====
// ---------------------------------------------------------------------------
// feature buffer geometry and stored feature layout
// ---------------------------------------------------------------------------
package oflow_core_pkg;

	// buffer geometry
	localparam int MEM_DEPTH  = 16;       // stored features per frame
	localparam int ADDR_LEN   = 4;        // log2 of MEM_DEPTH
	localparam int PAIR_LEN   = 3;        // one address bit less, two entries per read
	localparam int NUM_PAIRS  = MEM_DEPTH / 2; // pairs walked per search

	// feature layout
	localparam int ID_LEN     = 12;       // feature id
	localparam int FEAT_BYTES = 4;        // descriptor bytes
	localparam int BYTE_LEN   = 8;

	// read pipeline seen by the controller
	// buffer register, lane register, tracker register
	localparam int PIPE_DELAY = 3;

	// descriptor only, byte 0 in the low bits
	typedef struct packed {
		logic [FEAT_BYTES-1:0][BYTE_LEN-1:0] desc;
	} feature_t;                          // 32 bits

	// one buffer slot
	typedef struct packed {
		logic              valid;         // slot holds a live feature
		logic [ID_LEN-1:0] id;
		feature_t          feat;
	} entry_t;                            // 45 bits

endpackage

// ==== verilog/oflow_feature_mem.sv ====
`timescale 1ns/1ns

// ---------------------------------------------------------------------------
// feature buffer
// one write port, one read port returning the entry pair 2k / 2k+1
// ---------------------------------------------------------------------------
module oflow_feature_mem (
	input  logic                                   clk,
	input  logic                                   reset_N,

	// load side
	input  logic                                   wr_en,
	input  logic [oflow_core_pkg::ADDR_LEN-1:0]    wr_addr,
	input  oflow_core_pkg::entry_t                 wr_entry,

	// search side
	input  logic                                   rd_en,
	input  logic [oflow_core_pkg::PAIR_LEN-1:0]    rd_pair,
	output oflow_core_pkg::entry_t                 entry_0,  // even address
	output oflow_core_pkg::entry_t                 entry_1,  // odd address
	output logic                                   rd_valid
);

	import oflow_core_pkg::*;

	entry_t mem [MEM_DEPTH];           // register array

	// storage
	// reset empties every slot so a fresh buffer scores as MAX
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;           // valid = 0
		end else if (wr_en) begin
			mem[wr_addr] <= wr_entry;  // old value still seen by a read this edge
		end
	end

	// pair read, one cycle
	always_ff @(posedge clk) begin
		if (rd_en) begin
			entry_0 <= mem[{rd_pair, 1'b0}];
			entry_1 <= mem[{rd_pair, 1'b1}];
		end
	end

	// strobe follows the data
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

endmodule

// ==== verilog/oflow_match_ctrl.sv ====
`timescale 1ns/1ns

// ---------------------------------------------------------------------------
// search controller
// walks the buffer pair by pair and times the result strobe
// ---------------------------------------------------------------------------
module oflow_match_ctrl (
	input  logic                                clk,
	input  logic                                reset_N,

	// query side
	input  logic                                query_valid,
	input  oflow_core_pkg::feature_t            query_feat,
	output oflow_core_pkg::feature_t            query,        // held for the lanes

	// buffer side
	output logic                                rd_en,
	output logic [oflow_core_pkg::PAIR_LEN-1:0] rd_pair,

	// tracker side
	output logic                                clear,
	output logic                                result_valid
);

	import oflow_core_pkg::*;

	typedef enum logic {
		idle_st,
		scan_st
	} state_t;

	state_t              state;
	logic [PAIR_LEN-1:0] pair_cnt;     // next pair to read
	logic [PIPE_DELAY-1:0] drain;      // last pair moving down the pipe
	logic                start;        // query accepted
	logic                last_pair;    // final read this cycle

	// busy until the last pair leaves the lanes
	// the result cycle itself may take a new query
	assign start     = query_valid && (state == idle_st) && (drain[PIPE_DELAY-2:0] == '0);
	assign last_pair = (state == scan_st) && (pair_cnt == PAIR_LEN'(NUM_PAIRS - 1));

	// ------------------------------------------------------------------------
	// state, pair counter, strobes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state    <= idle_st;
			pair_cnt <= '0;
			clear    <= 1'b0;
			drain    <= '0;
		end else begin
			clear <= start;                                 // one cycle, ahead of pair 0
			drain <= {drain[PIPE_DELAY-2:0], last_pair};    // buffer, lane, tracker
			case (state)
				idle_st: begin
					if (start) begin
						state    <= scan_st;
						pair_cnt <= '0;
					end
				end
				scan_st: begin
					pair_cnt <= pair_cnt + 1'b1;
					if (last_pair)
						state <= idle_st;
				end
				default: state <= idle_st;
			endcase
		end
	end

	// query payload, taken once per search
	always_ff @(posedge clk) begin
		if (start)
			query <= query_feat;
	end

	assign rd_en        = (state == scan_st);  // cycles 1..8
	assign rd_pair      = pair_cnt;
	assign result_valid = drain[PIPE_DELAY-1]; // tracker has taken the last pair

endmodule

// ==== verilog/oflow_score_pkg.sv ====
// ---------------------------------------------------------------------------
// similarity scores and match results
// ---------------------------------------------------------------------------
package oflow_score_pkg;

	// sad of four bytes tops out at 4*255 = 1020
	localparam int SCORE_LEN = 10;

	// all ones, above any real sad
	// marks an empty slot or an invalid entry
	localparam logic [SCORE_LEN-1:0] MAX_SCORE = '1;

	// scored candidate from one lane
	typedef struct packed {
		logic [SCORE_LEN-1:0]              score;
		logic [oflow_core_pkg::ID_LEN-1:0] id;
	} cand_t;                             // 22 bits

	// two smallest so far, best <= second
	typedef struct packed {
		cand_t best;
		cand_t second;
	} match_t;                            // 44 bits

	// value of a slot that has seen nothing yet
	localparam cand_t EMPTY_CAND = '{score: MAX_SCORE, id: '0};

endpackage

// ==== verilog/oflow_similarity_metric.sv ====
`timescale 1ns/1ns

// ---------------------------------------------------------------------------
// similarity lane
// sum of absolute byte differences between a stored entry and the query
// ---------------------------------------------------------------------------
module oflow_similarity_metric (
	input  logic                       clk,
	input  logic                       reset_N,

	// from the buffer
	input  logic                       in_valid,
	input  oflow_core_pkg::entry_t     entry,
	input  oflow_core_pkg::feature_t   query,   // held by the controller

	// to the tracker
	output oflow_score_pkg::cand_t     cand,
	output logic                       cand_valid
);

	import oflow_core_pkg::*;
	import oflow_score_pkg::*;

	logic [SCORE_LEN-1:0] sad;         // combinational sum

	// |a - b| on one byte
	function automatic logic [BYTE_LEN-1:0] abs_diff(
		input logic [BYTE_LEN-1:0] a,
		input logic [BYTE_LEN-1:0] b
	);
		if (a > b)
			return a - b;
		else
			return b - a;
	endfunction

	// adder tree, folded into a loop
	always_comb begin
		sad = '0;
		for (int i = 0; i < FEAT_BYTES; i++)
			sad = sad + SCORE_LEN'(abs_diff(entry.feat.desc[i], query.desc[i]));
	end

	// ------------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (in_valid) begin
			cand.id    <= entry.id;
			cand.score <= entry.valid ? sad : MAX_SCORE;  // dead slot never wins
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			cand_valid <= 1'b0;
		else
			cand_valid <= in_valid;    // one stage, same as the score
	end

endmodule

// ==== vlog.f ====
verilog/oflow_core_pkg.sv
verilog/oflow_score_pkg.sv
verilog/oflow_feature_mem.sv
verilog/oflow_similarity_metric.sv
verilog/oflow_calc_min.sv
verilog/oflow_match_ctrl.sv
verilog/oflow_core.sv
test/tb_oflow_core.sv
